// ==== rtl/sprite_defines.svh ====
//======================================================================
// Raster and sprite sizes are fixed at build time and shared by all sprites
// With four sprites the background address 4'hF hides the enable of sprite 3
//======================================================================
`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

`define H_ACTIVE 64 // Visible pixels per line
`define H_TOTAL 80 // Pixels per line including blanking
`define V_ACTIVE 48 // Visible lines per frame
`define V_TOTAL 52 // Lines per frame including blanking

`define SPRITE_WIDTH 8
`define SPRITE_HEIGHT 6
`define SPRITE_COUNT 2 // 1 to 4

`define REG_BACKGROUND 4'hF
`define REG_POS_X 2'd0 // Field offsets inside a sprite's 4-address slot
`define REG_POS_Y 2'd1
`define REG_COLOR 2'd2
`define REG_ENABLE 2'd3

`endif

// ==== rtl/sprite_pkg.sv ====
//======================================================================
// Coordinates are unsigned and colours are palette indices
//======================================================================
package sprite_pkg;

	typedef logic [10:0] coord_t; // Pixel or line number
	typedef logic [7:0] color_t; // Palette index
	typedef logic [3:0] reg_addr_t;

	// One sprite's settings as held by the register block
	typedef struct packed {
		coord_t pos_x; // Left edge
		coord_t pos_y; // Top edge
		color_t color;
		logic enable;
	} sprite_cfg_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic hblank;
		logic vblank;
	} video_pos_t;

	typedef struct packed {
		color_t data;
		logic mask; // Pixel is covered by a sprite
	} overlay_t;

endpackage

// ==== rtl/video_timing.sv ====
//======================================================================
// Free-running raster with no sync pulses
// Blanking is registered with the counters and matches the coordinate
//======================================================================
`timescale 1ns/100ps
`include "sprite_defines.svh"

module video_timing (
	input logic i_clock,
	input logic i_arst_n,
	output sprite_pkg::video_pos_t o_pos
);

	import sprite_pkg::*;

	coord_t x_next;
	coord_t y_next;
	video_pos_t pos_next;

	//======================================================================
	// Next raster position
	//======================================================================
	always_comb begin
		x_next = o_pos.x + coord_t'(1);
		y_next = o_pos.y;
		if (o_pos.x == coord_t'(`H_TOTAL - 1)) begin
			x_next = '0; // Wrap to start of next line
			if (o_pos.y == coord_t'(`V_TOTAL - 1)) begin
				y_next = '0; // Wrap to top of frame
			end else begin
				y_next = o_pos.y + coord_t'(1);
			end
		end
	end

	always_comb begin
		pos_next.x = x_next;
		pos_next.y = y_next;
		pos_next.hblank = (x_next >= coord_t'(`H_ACTIVE)); // Right margin
		pos_next.vblank = (y_next >= coord_t'(`V_ACTIVE)); // Bottom margin
	end

	//======================================================================
	// Counter registers
	//======================================================================
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pos <= '0; // Pixel 0 of line 0 is active
		end else begin
			o_pos <= pos_next;
		end
	end

endmodule

// ==== rtl/sprite_regs.sv ====
//======================================================================
// Write-only registers with no back-pressure, one request per cycle
// o_ready pulses for every request, also for unused addresses
//======================================================================
`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_regs (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_request,
	input sprite_pkg::reg_addr_t i_address,
	input logic [31:0] i_wdata,
	output logic o_ready,

	output sprite_pkg::sprite_cfg_t [`SPRITE_COUNT-1:0] o_sprite_cfg,
	output sprite_pkg::color_t o_background
);

	import sprite_pkg::*;

	logic [1:0] addr_sprite;
	logic [1:0] addr_field;
	logic bg_hit;

	//======================================================================
	// Address decode
	//======================================================================
	assign addr_sprite = i_address[3:2]; // Sprite n owns 4n to 4n+3
	assign addr_field = i_address[1:0];
	assign bg_hit = (i_address == `REG_BACKGROUND);

	//======================================================================
	// Configuration flops and ready pulse
	//======================================================================
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ready <= 1'b0;
			o_sprite_cfg <= '0; // All sprites disabled
			o_background <= '0;
		end else begin
			o_ready <= i_request; // One cycle per accepted request

			if (i_request && bg_hit) begin
				o_background <= i_wdata[$bits(color_t)-1:0];
			end

			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				if (i_request && !bg_hit && (addr_sprite == 2'(n))) begin
					case (addr_field)
						`REG_POS_X: begin
							o_sprite_cfg[n].pos_x <= i_wdata[$bits(coord_t)-1:0];
						end
						`REG_POS_Y: begin
							o_sprite_cfg[n].pos_y <= i_wdata[$bits(coord_t)-1:0];
						end
						`REG_COLOR: begin
							o_sprite_cfg[n].color <= i_wdata[$bits(color_t)-1:0];
						end
						`REG_ENABLE: begin
							o_sprite_cfg[n].enable <= i_wdata[0];
						end
					endcase
				end
			end
		end
	end

endmodule

// ==== rtl/sprite_unit.sv ====
//======================================================================
// Solid rectangle only, result is one cycle after the coordinate
//======================================================================
`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_unit #(
	parameter int WIDTH = `SPRITE_WIDTH,
	parameter int HEIGHT = `SPRITE_HEIGHT
) (
	input logic i_clock,
	input logic i_arst_n,
	input sprite_pkg::sprite_cfg_t i_cfg,
	input sprite_pkg::video_pos_t i_pos,
	output sprite_pkg::overlay_t o_overlay
);

	logic [31:0] x_limit;
	logic [31:0] y_limit;
	logic in_x;
	logic in_y;
	logic visible;
	logic hit;

	//======================================================================
	// Rectangle test
	//======================================================================
	// Exclusive right and bottom edges, wide enough not to wrap
	assign x_limit = 32'(i_cfg.pos_x) + 32'(WIDTH);
	assign y_limit = 32'(i_cfg.pos_y) + 32'(HEIGHT);

	assign in_x = (i_pos.x >= i_cfg.pos_x) && (32'(i_pos.x) < x_limit);
	assign in_y = (i_pos.y >= i_cfg.pos_y) && (32'(i_pos.y) < y_limit);

	assign visible = !(i_pos.hblank || i_pos.vblank);
	assign hit = i_cfg.enable && visible && in_x && in_y;

	//======================================================================
	// Output register
	//======================================================================
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_overlay <= '0;
		end else begin
			o_overlay.mask <= hit;
			o_overlay.data <= i_cfg.color; // Only meaningful with mask set
		end
	end

endmodule

// ==== rtl/sprite_overlay.sv ====
//======================================================================
// Lowest sprite index wins where sprites overlap
// Overlay data is 0 where no sprite covers the pixel
//======================================================================
`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_overlay (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_request,
	input sprite_pkg::reg_addr_t i_address,
	input logic [31:0] i_wdata,
	output logic o_ready,

	input sprite_pkg::video_pos_t i_pos,
	output sprite_pkg::overlay_t o_overlay,
	output sprite_pkg::color_t o_background
);

	import sprite_pkg::*;

	sprite_cfg_t [`SPRITE_COUNT-1:0] sprite_cfg;
	overlay_t [`SPRITE_COUNT-1:0] unit_overlay;

	sprite_regs u_regs (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_sprite_cfg(sprite_cfg),
		.o_background(o_background)
	);

	for (genvar n = 0; n < `SPRITE_COUNT; n++) begin : g_sprite
		sprite_unit #(
			.WIDTH(`SPRITE_WIDTH),
			.HEIGHT(`SPRITE_HEIGHT)
		) u_sprite (
			.i_clock(i_clock),
			.i_arst_n(i_arst_n),
			.i_cfg(sprite_cfg[n]),
			.i_pos(i_pos),
			.o_overlay(unit_overlay[n])
		);
	end

	//======================================================================
	// Fixed priority select
	//======================================================================
	always_comb begin
		o_overlay = '0;
		// Walk downward so the lowest covering index is assigned last
		for (int n = `SPRITE_COUNT - 1; n >= 0; n--) begin
			if (unit_overlay[n].mask) begin
				o_overlay = unit_overlay[n];
			end
		end
	end

endmodule

// ==== rtl/pixel_mixer.sv ====
//======================================================================
// Expects the overlay one cycle behind the raster position
//======================================================================
`timescale 1ns/100ps

module pixel_mixer (
	input logic i_clock,
	input logic i_arst_n,
	input sprite_pkg::video_pos_t i_pos,
	input sprite_pkg::overlay_t i_overlay,
	input sprite_pkg::color_t i_background,
	output sprite_pkg::color_t o_pixel,
	output logic o_hblank,
	output logic o_vblank
);

	import sprite_pkg::*;

	logic hblank_d;
	logic vblank_d;
	color_t background_d;

	//======================================================================
	// Alignment stage and output register
	//======================================================================
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			hblank_d <= 1'b0;
			vblank_d <= 1'b0;
			background_d <= '0;
			o_pixel <= '0;
			o_hblank <= 1'b0;
			o_vblank <= 1'b0;
		end else begin
			hblank_d <= i_pos.hblank; // Lines up with sprite unit output
			vblank_d <= i_pos.vblank;
			background_d <= i_background; // Same stage as the sprite registers
			o_hblank <= hblank_d;
			o_vblank <= vblank_d;
			if (hblank_d || vblank_d) begin
				o_pixel <= '0; // Black in blanking
			end else if (i_overlay.mask) begin
				o_pixel <= i_overlay.data;
			end else begin
				o_pixel <= background_d;
			end
		end
	end

endmodule

// ==== rtl/video_sprite_top.sv ====
//======================================================================
// Pixel output is two cycles behind the raster counters
// Register writes apply to positions generated after the write edge
//======================================================================
`timescale 1ns/100ps

module video_sprite_top (
	input logic i_clock,
	input logic i_arst_n,

	// Register write port
	input logic i_request,
	input sprite_pkg::reg_addr_t i_address,
	input logic [31:0] i_wdata,
	output logic o_ready,

	// Video out
	output sprite_pkg::color_t o_pixel,
	output logic o_hblank,
	output logic o_vblank
);

	import sprite_pkg::*;

	video_pos_t pos;
	overlay_t overlay;
	color_t background;

	video_timing u_timing (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.o_pos(pos)
	);

	sprite_overlay u_overlay (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.i_pos(pos),
		.o_overlay(overlay),
		.o_background(background)
	);

	pixel_mixer u_mixer (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_pos(pos),
		.i_overlay(overlay),
		.i_background(background),
		.o_pixel(o_pixel),
		.o_hblank(o_hblank),
		.o_vblank(o_vblank)
	);

endmodule

// ==== tests/tb_tasks.svh ====
//======================================================================
// Reference pixel model and directed tests, included in the testbench top
//======================================================================

	coord_t model_pos_x [`SPRITE_COUNT];
	coord_t model_pos_y [`SPRITE_COUNT];
	color_t model_color [`SPRITE_COUNT];
	logic model_enable [`SPRITE_COUNT];
	color_t model_background;

	task automatic clear_model();
		for (int n = 0; n < `SPRITE_COUNT; n++) begin
			model_pos_x[n] = '0;
			model_pos_y[n] = '0;
			model_color[n] = '0;
			model_enable[n] = 1'b0;
		end
		model_background = '0;
	endtask

	// First enabled sprite in index order that covers the pixel
	function automatic color_t expected_pixel(input int x, input int y);
		color_t result;
		logic found;
		result = model_background;
		found = 1'b0;
		for (int n = 0; n < `SPRITE_COUNT; n++) begin
			if (!found && model_enable[n]
					&& x >= int'(model_pos_x[n]) && x < int'(model_pos_x[n]) + `SPRITE_WIDTH
					&& y >= int'(model_pos_y[n]) && y < int'(model_pos_y[n]) + `SPRITE_HEIGHT) begin
				result = model_color[n];
				found = 1'b1;
			end
		end
		return result;
	endfunction

	task automatic check_ready(input logic expected);
		assert (o_ready == expected) else begin
			$display("FAIL o_ready expected 0x%0h got 0x%0h", expected, o_ready);
			stop_with_error();
		end
	endtask

	task automatic write_reg(input reg_addr_t address, input logic [31:0] data);
		int cycles;
		int n;
		@(negedge i_clock);
		check_ready(1'b0); // Previous cycle had no request
		i_request = 1'b1;
		i_address = address;
		i_wdata = data;
		cycles = 0;
		do begin
			@(negedge i_clock);
			cycles++;
		end while (!o_ready && cycles < READY_TIMEOUT);
		if (!o_ready) begin
			$display("Timeout waiting for o_ready after a write to address 0x%0h", address);
			stop_with_error();
		end
		assert (cycles == 1) else begin
			$display("FAIL o_ready latency expected 0x1 got 0x%0h", cycles);
			stop_with_error();
		end
		i_request = 1'b0;
		n = int'(address[3:2]);
		if (address == `REG_BACKGROUND) begin
			model_background = data[7:0];
		end else if (n < `SPRITE_COUNT) begin // Unused slots change nothing
			case (address[1:0])
				2'd0: model_pos_x[n] = data[10:0];
				2'd1: model_pos_y[n] = data[10:0];
				2'd2: model_color[n] = data[7:0];
				default: model_enable[n] = data[0];
			endcase
		end
	endtask

	task automatic set_sprite(input int n, input int x, input int y, input color_t color,
			input logic enable);
		write_reg(reg_addr_t'(4 * n), 32'(x));
		write_reg(reg_addr_t'(4 * n + 1), 32'(y));
		write_reg(reg_addr_t'(4 * n + 2), 32'(color));
		write_reg(reg_addr_t'(4 * n + 3), 32'(enable));
	endtask

	//======================================================================
	// Directed tests
	//======================================================================
	task automatic check_ready_handshake();
		check_ready(1'b0); // Right after reset
		write_reg(`REG_BACKGROUND, 32'h0000_0011);
		write_reg(reg_addr_t'(4 * `SPRITE_COUNT + 3), 32'hFFFF_FFFF); // Unused address
		write_reg(reg_addr_t'(2), 32'h0000_0022);
		@(negedge i_clock);
		check_ready(1'b0);
	endtask

	task automatic show_background_only();
		write_reg(`REG_BACKGROUND, 32'h0000_005A);
		check_frame();
	endtask

	task automatic place_single_sprite();
		set_sprite(0, 10, 12, 8'hC3, 1'b1);
		check_frame();
	endtask

	task automatic overlap_priority();
		set_sprite(1, 14, 15, 8'h3C, 1'b1); // Overlaps sprite 0 at its lower right
		check_frame();
	endtask

	task automatic disable_and_clip();
		write_reg(reg_addr_t'(3), 32'h0);
		check_frame();
		set_sprite(1, `H_ACTIVE - 3, `V_ACTIVE - 2, 8'h77, 1'b1); // Corner clip
		set_sprite(0, `H_ACTIVE - 5, 20, 8'h99, 1'b1); // Right edge clip
		check_frame();
	endtask

	task automatic run_random_frames();
		int seed;
		logic [31:0] r;
		seed = 32'h6055_ca1f;
		for (int frame = 0; frame < 4; frame++) begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				r = $random(seed);
				set_sprite(n, int'(r[7:0]) % (`H_ACTIVE + `SPRITE_WIDTH),
					int'(r[15:8]) % (`V_ACTIVE + `SPRITE_HEIGHT), r[23:16], r[24]);
			end
			r = $random(seed);
			write_reg(`REG_BACKGROUND, r); // Upper bits must be dropped
			check_frame();
		end
	endtask

// ==== tests/tb_video_sprite.sv ====
//======================================================================
// Frames are tracked from o_hblank and o_vblank only, no internal probes
// Register writes are made in vertical blanking and apply from the next frame
//======================================================================
`timescale 1ns/100ps
`include "sprite_defines.svh"

module tb_video_sprite;

	import sprite_pkg::*;

	localparam int READY_TIMEOUT = 16;
	localparam int FRAME_TIMEOUT = 3 * `H_TOTAL * `V_TOTAL;

	logic i_clock;
	logic i_arst_n;
	logic i_request;
	reg_addr_t i_address;
	logic [31:0] i_wdata;
	logic o_ready;
	color_t o_pixel;
	logic o_hblank;
	logic o_vblank;

	video_sprite_top u_dut (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_pixel(o_pixel),
		.o_hblank(o_hblank),
		.o_vblank(o_vblank)
	);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock; // 8 ns period
	end

	`include "tb_tasks.svh"

	task automatic stop_with_error();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_blank_pixel();
		assert (o_pixel == '0) else begin
			$display("FAIL o_pixel in blanking expected 0x00 got 0x%02h", o_pixel);
			stop_with_error();
		end
	endtask

	//======================================================================
	// Frame tracker
	//======================================================================
	task automatic wait_vblank(input logic level);
		int cycles;
		cycles = 0;
		while (o_vblank != level && cycles < FRAME_TIMEOUT) begin
			if (o_vblank || o_hblank) begin
				check_blank_pixel();
			end
			@(negedge i_clock);
			cycles++;
		end
		if (o_vblank != level) begin
			$display("Timeout waiting for o_vblank to become %0d", level);
			stop_with_error();
		end
	endtask

	// Returns on pixel (0,0) of the first frame that starts after the call
	task automatic wait_frame_start();
		wait_vblank(1'b0);
		wait_vblank(1'b1);
		wait_vblank(1'b0);
	endtask

	task automatic check_frame();
		int x;
		int y;
		int cycles;
		logic hblank_prev;
		color_t expected;
		wait_frame_start();
		x = 0;
		y = 0;
		cycles = 0;
		hblank_prev = 1'b0;
		while (!o_vblank && cycles < FRAME_TIMEOUT) begin
			if (!o_hblank) begin
				expected = expected_pixel(x, y);
				assert (o_pixel == expected) else begin
					$display("FAIL o_pixel at x=%0d y=%0d expected 0x%02h got 0x%02h",
						x, y, expected, o_pixel);
					stop_with_error();
				end
				x++;
			end else begin
				if (!hblank_prev) begin // End of an active line
					assert (x == `H_ACTIVE) else begin
						$display("FAIL active pixels of line %0d expected 0x%0h got 0x%0h",
							y, `H_ACTIVE, x);
						stop_with_error();
					end
					y++;
					x = 0;
				end
				check_blank_pixel();
			end
			hblank_prev = o_hblank;
			@(negedge i_clock);
			cycles++;
		end
		if (!o_vblank) begin
			$display("Timeout waiting for the end of the active frame");
			stop_with_error();
		end
		assert (y == `V_ACTIVE) else begin
			$display("FAIL active lines expected 0x%0h got 0x%0h", `V_ACTIVE, y);
			stop_with_error();
		end
	endtask

	//======================================================================
	// Test sequence
	//======================================================================
	initial begin
		i_arst_n = 1'b0;
		i_request = 1'b0;
		i_address = '0;
		i_wdata = '0;
		clear_model();
		repeat (5) @(negedge i_clock);
		i_arst_n = 1'b1;

		check_ready_handshake();
		show_background_only();
		place_single_sprite();
		overlap_priority();
		disable_and_clip();
		run_random_frames();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+rtl
+incdir+tests
rtl/sprite_pkg.sv
rtl/video_timing.sv
rtl/sprite_regs.sv
rtl/sprite_unit.sv
rtl/sprite_overlay.sv
rtl/pixel_mixer.sv
rtl/video_sprite_top.sv
tests/tb_video_sprite.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_video_sprite
FILE_LIST  := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Test run FAILED"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Test run ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
